// File: hw/ipod_pkg.sv
package ipod_pkg;

  // ====================
  // Basic widths
  // ====================

  // Word address into the 32-bit flash
  typedef logic [22:0] flash_word_addr_t;

  // Upper bits pick the word, bit 0 picks the half
  typedef logic [23:0] sample_index_t;

  typedef logic [15:0] sample_t;

  // Sample period counted in CLK_50M cycles
  typedef logic [15:0] period_t;

  // Active-low segments, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // One flash word, read either raw or as two samples
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      sample_t hi;
      sample_t lo;
    } pair;
  } flash_word_u;

  // ====================
  // Stage payloads
  // ====================

  typedef struct packed {
    logic start;
    logic stop;
    logic forward;
    logic backward;
    logic restart;
  } play_cmd_t;

  typedef struct packed {
    sample_index_t index;
  } fetch_req_t;

  // Wishbone classic, read-only master side
  typedef struct packed {
    logic             cyc;
    logic             stb;
    flash_word_addr_t adr;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    flash_word_u dat;
  } wb_s2m_t;

  // Upper-case keys, lower case sits 32 above
  localparam logic [7:0] ascii_e = 8'h45;
  localparam logic [7:0] ascii_d = 8'h44;
  localparam logic [7:0] ascii_f = 8'h46;
  localparam logic [7:0] ascii_b = 8'h42;
  localparam logic [7:0] ascii_r = 8'h52;

endpackage

// File: hw/key_command_decoder.sv
`timescale 1ns/1ps

module key_command_decoder (
  input  logic                CLK_50M,
  input  logic                reset,
  input  logic [7:0]          key_ascii,
  input  logic                key_strobe,
  output ipod_pkg::play_cmd_t cmd
);
  import ipod_pkg::*;

  play_cmd_t cmd_next;

  // True when the byte is the letter in either case
  function automatic logic is_letter(input logic [7:0] code, input logic [7:0] upper);
    logic [7:0] lower;
    lower = upper + 8'd32;
    return (code == upper) || (code == lower);
  endfunction

  // ====================
  // Letter match
  // ====================

  always_comb
  begin
    cmd_next = '0;
    if (key_strobe)
    begin
      cmd_next.start    = is_letter(key_ascii, ascii_e);
      cmd_next.stop     = is_letter(key_ascii, ascii_d);
      cmd_next.forward  = is_letter(key_ascii, ascii_f);
      cmd_next.backward = is_letter(key_ascii, ascii_b);
      cmd_next.restart  = is_letter(key_ascii, ascii_r);
    end
  end

  // One-cycle command pulse
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      cmd <= '0;
    else
      cmd <= cmd_next;
  end

  // Sequencer applies flags in a fixed order and expects a single one
  a_single_flag: assert property (
    @(posedge CLK_50M) disable iff (reset)
    $onehot0(cmd)
  ) else $error("more than one command flag set: %b", cmd);

endmodule

// File: hw/speed_control.sv
`timescale 1ns/1ps

module speed_control #(
  parameter ipod_pkg::period_t default_period = 16'd2272,
  parameter ipod_pkg::period_t period_step    = 16'd100,
  parameter ipod_pkg::period_t min_period     = 16'd200,
  parameter ipod_pkg::period_t max_period     = 16'd60000
) (
  input  logic              CLK_50M,
  input  logic              reset,
  input  logic              speed_up,
  input  logic              speed_down,
  input  logic              speed_reset,
  output ipod_pkg::period_t period,
  output logic              sample_tick
);
  import ipod_pkg::*;

  period_t     period_next;
  period_t     tick_count;
  logic [16:0] up_floor;
  logic [16:0] down_sum;

  // Extra bit keeps the limit checks free of wraparound
  assign up_floor = {1'b0, min_period} + {1'b0, period_step};
  assign down_sum = {1'b0, period} + {1'b0, period_step};

  // ====================
  // Period update
  // ====================

  always_comb
  begin
    period_next = period;
    if (speed_reset)
      period_next = default_period;
    else if (speed_up)
    begin
      if ({1'b0, period} < up_floor)
        period_next = min_period;
      else
        period_next = period - period_step;
    end
    else if (speed_down)
    begin
      if (down_sum > {1'b0, max_period})
        period_next = max_period;
      else
        period_next = down_sum[15:0];
    end
  end

  // Divider restarts whenever the period moves
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      period      <= default_period;
      tick_count  <= '0;
      sample_tick <= 1'b0;
    end
    else
    begin
      period <= period_next;
      if (period_next != period)
      begin
        tick_count  <= '0;
        sample_tick <= 1'b0;
      end
      else if (tick_count == period - 16'd1)
      begin
        tick_count  <= '0;
        sample_tick <= 1'b1;
      end
      else
      begin
        tick_count  <= tick_count + 16'd1;
        sample_tick <= 1'b0;
      end
    end
  end

  a_period_in_range: assert property (
    @(posedge CLK_50M) disable iff (reset)
    (period >= min_period) && (period <= max_period)
  ) else $error("period %0d outside %0d..%0d", period, min_period, max_period);

endmodule

// File: hw/address_sequencer.sv
`timescale 1ns/1ps

module address_sequencer #(
  parameter ipod_pkg::flash_word_addr_t song_last_word = 23'h7FFFF
) (
  input  logic                 CLK_50M,
  input  logic                 reset,
  input  ipod_pkg::play_cmd_t  cmd,
  input  logic                 sample_tick,
  output ipod_pkg::fetch_req_t fetch_req,
  output logic                 fetch_valid,
  input  logic                 fetch_ready
);
  import ipod_pkg::*;

  // Odd half of the last word
  localparam sample_index_t last_index = {song_last_word, 1'b1};

  logic          playing;
  logic          forward;
  sample_index_t index;
  sample_index_t restart_index;
  logic          cmd_play;
  logic          issue;
  logic          transfer;

  // Next index in the play direction, wrapping at both ends
  function automatic sample_index_t step_index(input sample_index_t cur, input logic fwd);
    sample_index_t nxt;
    if (fwd)
      nxt = (cur == last_index) ? '0 : cur + 24'd1;
    else
      nxt = (cur == '0) ? last_index : cur - 24'd1;
    return nxt;
  endfunction

  assign restart_index = forward ? '0 : last_index;

  // Start or stop beats a tick in the same cycle
  assign cmd_play = cmd.start | cmd.stop;
  assign issue    = sample_tick & playing & ~cmd_play & ~fetch_valid;
  assign transfer = fetch_valid & fetch_ready;

  // ====================
  // Play state
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing     <= 1'b0;
      forward     <= 1'b1;
      index       <= '0;
      fetch_valid <= 1'b0;
    end
    else
    begin
      if (cmd.start)
        playing <= 1'b1;
      else if (cmd.stop)
        playing <= 1'b0;

      if (cmd.forward)
        forward <= 1'b1;
      else if (cmd.backward)
        forward <= 1'b0;

      if (cmd.restart)
        index <= restart_index;
      else if (transfer)
        index <= step_index(index, forward);

      if (issue)
        fetch_valid <= 1'b1;
      else if (transfer)
        fetch_valid <= 1'b0;
    end
  end

  // Request payload
  always_ff @(posedge CLK_50M)
  begin
    if (issue)
      fetch_req.index <= cmd.restart ? restart_index : index;
  end

  // Reader must be idle by the next tick or that sample is dropped
  a_no_lost_tick: assert property (
    @(posedge CLK_50M) disable iff (reset)
    (sample_tick && playing) |-> (!fetch_valid && fetch_ready)
  ) else $error("sample tick lost, fetch still pending");

endmodule

// File: hw/flash_wb_reader.sv
`timescale 1ns/1ps

module flash_wb_reader (
  input  logic                 CLK_50M,
  input  logic                 reset,
  input  ipod_pkg::fetch_req_t fetch_req,
  input  logic                 fetch_valid,
  output logic                 fetch_ready,
  output ipod_pkg::wb_m2s_t    wb_out,
  input  ipod_pkg::wb_s2m_t    wb_in,
  output ipod_pkg::sample_t    audio_sample,
  output logic                 sample_valid
);
  import ipod_pkg::*;

  flash_word_u word;
  logic        odd_half;
  logic        transfer;
  logic        bus_done;

  // Idle whenever no bus cycle is open
  assign fetch_ready = ~wb_out.cyc;
  assign transfer    = fetch_valid & fetch_ready;
  assign bus_done    = wb_out.cyc & wb_out.stb & wb_in.ack;

  // ====================
  // Bus cycle control
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      wb_out       <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= bus_done;
      if (transfer)
      begin
        wb_out.cyc <= 1'b1;
        wb_out.stb <= 1'b1;
        wb_out.adr <= fetch_req.index[23:1];
      end
      else if (bus_done)
      begin
        wb_out.cyc <= 1'b0;
        wb_out.stb <= 1'b0;
      end
    end
  end

  // Captured word and half select
  always_ff @(posedge CLK_50M)
  begin
    if (transfer)
      odd_half <= fetch_req.index[0];
    if (bus_done)
      word <= wb_in.dat;
  end

  // Even index plays lo, odd index plays hi
  assign audio_sample = odd_half ? word.pair.hi : word.pair.lo;

  a_adr_stable: assert property (
    @(posedge CLK_50M) disable iff (reset)
    (wb_out.stb && !wb_in.ack) |=> (wb_out.stb && $stable(wb_out.adr))
  ) else $error("adr or stb changed before ack");

endmodule

// File: hw/period_display.sv
`timescale 1ns/1ps

module period_display (
  input  logic                    CLK_50M,
  input  logic                    reset,
  input  ipod_pkg::period_t       period,
  output ipod_pkg::seg_t    [5:0] hex
);
  import ipod_pkg::*;

  logic [23:0] value;

  // Hex glyphs, active low, bit 0 is segment a
  function automatic seg_t glyph(input logic [3:0] nibble);
    seg_t seg;
    case (nibble)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  assign value = {8'h00, period};

  // ====================
  // Digit registers
  // ====================

  // Blank during reset, digit 0 is the lowest nibble
  always_ff @(posedge CLK_50M)
  begin
    for (int i = 0; i < 6; i++)
    begin
      if (reset)
        hex[i] <= 7'h7F;
      else
        hex[i] <= glyph(value[i*4 +: 4]);
    end
  end

endmodule

// File: hw/ipod_top.sv
`timescale 1ns/1ps

module ipod_top #(
  parameter ipod_pkg::period_t          default_period = 16'd2272,
  parameter ipod_pkg::period_t          period_step    = 16'd100,
  parameter ipod_pkg::period_t          min_period     = 16'd200,
  parameter ipod_pkg::period_t          max_period     = 16'd60000,
  parameter ipod_pkg::flash_word_addr_t song_last_word = 23'h7FFFF
) (
  input  logic                    CLK_50M,
  input  logic                    reset,
  input  logic [7:0]              key_ascii,
  input  logic                    key_strobe,
  input  logic                    speed_up,
  input  logic                    speed_down,
  input  logic                    speed_reset,
  output ipod_pkg::wb_m2s_t       wb_out,
  input  ipod_pkg::wb_s2m_t       wb_in,
  output ipod_pkg::sample_t       audio_sample,
  output logic                    sample_valid,
  output ipod_pkg::seg_t    [5:0] hex
);
  import ipod_pkg::*;

  play_cmd_t  cmd;
  period_t    period;
  logic       sample_tick;
  fetch_req_t fetch_req;
  logic       fetch_valid;
  logic       fetch_ready;

  // ====================
  // Decode and execute
  // ====================

  key_command_decoder u_key_command_decoder (
    .CLK_50M    (CLK_50M),
    .reset      (reset),
    .key_ascii  (key_ascii),
    .key_strobe (key_strobe),
    .cmd        (cmd)
  );

  speed_control #(
    .default_period (default_period),
    .period_step    (period_step),
    .min_period     (min_period),
    .max_period     (max_period)
  ) u_speed_control (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .period      (period),
    .sample_tick (sample_tick)
  );

  address_sequencer #(
    .song_last_word (song_last_word)
  ) u_address_sequencer (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .cmd         (cmd),
    .sample_tick (sample_tick),
    .fetch_req   (fetch_req),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready)
  );

  // Flash read and display
  flash_wb_reader u_flash_wb_reader (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .wb_out       (wb_out),
    .wb_in        (wb_in),
    .audio_sample (audio_sample),
    .sample_valid (sample_valid)
  );

  period_display u_period_display (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .period  (period),
    .hex     (hex)
  );

endmodule

// File: bench/flash_wb_model.sv
`timescale 1ns/1ps

module flash_wb_model (
  input  logic              CLK_50M,
  input  logic              reset,
  input  ipod_pkg::wb_m2s_t bus_req,
  output ipod_pkg::wb_s2m_t bus_rsp
);
  import ipod_pkg::*;

  logic [31:0] rng_state;
  logic [31:0] rng_next;
  logic        busy;
  logic [2:0]  waits_left;
  logic        request;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Word n holds samples 2n and 2n+1, so each sample equals its index
  function automatic flash_word_u word_at(input flash_word_addr_t adr);
    flash_word_u w;
    logic [15:0] base;
    base      = {adr[14:0], 1'b0};
    w.pair.lo = base;
    w.pair.hi = base + 16'd1;
    return w;
  endfunction

  assign rng_next = xorshift(rng_state);
  assign request  = bus_req.cyc & bus_req.stb & ~bus_rsp.ack;

  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      bus_rsp    <= '0;
      rng_state  <= 32'd61413;
      busy       <= 1'b0;
      waits_left <= '0;
    end
    else
    begin
      bus_rsp <= '0;
      if (request && !busy)
      begin
        // New cycle, draw 0 to 7 wait states
        rng_state <= rng_next;
        if (rng_next[2:0] == 3'd0)
        begin
          bus_rsp.ack <= 1'b1;
          bus_rsp.dat <= word_at(bus_req.adr);
        end
        else
        begin
          busy       <= 1'b1;
          waits_left <= rng_next[2:0] - 3'd1;
        end
      end
      else if (request && busy)
      begin
        if (waits_left == 3'd0)
        begin
          busy        <= 1'b0;
          bus_rsp.ack <= 1'b1;
          bus_rsp.dat <= word_at(bus_req.adr);
        end
        else
          waits_left <= waits_left - 3'd1;
      end
    end
  end

endmodule

// File: bench/tb_ipod.sv
`timescale 1ns/1ps

module tb_ipod;
  import ipod_pkg::*;

  localparam int unsigned tb_default_period = 400;
  localparam int unsigned tb_period_step    = 100;
  localparam int unsigned tb_min_period     = 200;
  localparam int unsigned tb_max_period     = 60000;
  localparam int unsigned tb_last_index     = 31;
  localparam int          sample_timeout    = 1000;

  logic        CLK_50M;
  logic        reset;
  logic [7:0]  key_ascii;
  logic        key_strobe;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  wb_m2s_t     flash_req;
  wb_s2m_t     flash_rsp;
  sample_t     audio_sample;
  logic        sample_valid;
  seg_t [5:0]  hex;

  // Reference model state
  logic        exp_playing;
  logic        exp_forward;
  int unsigned exp_index;
  int unsigned exp_period;
  int unsigned settle;
  logic [41:0] exp_hex;
  int          error_count;
  int          test_count;
  int          test_start_errors;
  int          sample_count;

  ipod_top #(
    .default_period (16'd400),
    .period_step    (16'd100),
    .min_period     (16'd200),
    .song_last_word (23'd15)
  ) u_dut (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .key_ascii    (key_ascii),
    .key_strobe   (key_strobe),
    .speed_up     (speed_up),
    .speed_down   (speed_down),
    .speed_reset  (speed_reset),
    .wb_out       (flash_req),
    .wb_in        (flash_rsp),
    .audio_sample (audio_sample),
    .sample_valid (sample_valid),
    .hex          (hex)
  );

  flash_wb_model u_flash (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .bus_req (flash_req),
    .bus_rsp (flash_rsp)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  // Standard active-high glyphs, inverted for the display
  function automatic logic [6:0] glyph_of(input logic [3:0] n);
    logic [6:0] lit;
    case (n)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  function automatic logic [41:0] expected_hex(input int unsigned p);
    logic [41:0] digits;
    logic [23:0] v;
    v = p[23:0];
    for (int i = 0; i < 6; i++)
      digits[i*7 +: 7] = glyph_of(v[i*4 +: 4]);
    return digits;
  endfunction

  function automatic int unsigned next_index(input int unsigned cur, input logic fwd);
    if (fwd)
      return (cur == tb_last_index) ? 0 : cur + 1;
    return (cur == 0) ? tb_last_index : cur - 1;
  endfunction

  assign exp_hex = expected_hex(exp_period);

  // ====================
  // Reference model
  // ====================

  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      exp_playing  <= 1'b0;
      exp_forward  <= 1'b1;
      exp_index    <= 0;
      exp_period   <= tb_default_period;
      settle       <= 1;
      sample_count <= 0;
    end
    else
    begin
      if (settle != 0)
        settle <= settle - 1;
      // Bit 5 folds upper case onto lower case
      if (key_strobe)
      begin
        case (key_ascii | 8'h20)
          8'h65: exp_playing <= 1'b1;
          8'h64: exp_playing <= 1'b0;
          8'h66: exp_forward <= 1'b1;
          8'h62: exp_forward <= 1'b0;
          8'h72: exp_index <= exp_forward ? 0 : tb_last_index;
          default: ;
        endcase
      end
      if (sample_valid)
      begin
        exp_index    <= next_index(exp_index, exp_forward);
        sample_count <= sample_count + 1;
      end
      if (speed_reset)
        exp_period <= tb_default_period;
      else if (speed_up)
        exp_period <= (exp_period < tb_min_period + tb_period_step) ?
                      tb_min_period : exp_period - tb_period_step;
      else if (speed_down)
        exp_period <= (exp_period + tb_period_step > tb_max_period) ?
                      tb_max_period : exp_period + tb_period_step;
      // Display lags the pulse by 2 cycles
      if (speed_reset || speed_up || speed_down)
        settle <= 1;
    end
  end

  task automatic report_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
    error_count = error_count + 1;
    $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
  endtask

  task automatic report_event(input string what);
    error_count = error_count + 1;
    $display("[ERROR] t=%0t %s", $time, what);
  endtask

  // ====================
  // Checks
  // ====================

  a_sample_value: assert property (
    @(posedge CLK_50M) disable iff (reset)
    sample_valid |-> (audio_sample == 16'(exp_index))
  ) else report_value("audio_sample", $sampled(exp_index), $sampled(audio_sample));

  a_sample_when_playing: assert property (
    @(posedge CLK_50M) disable iff (reset)
    sample_valid |-> exp_playing
  ) else report_event("sample_valid pulsed while playback was stopped");

  a_sample_after_ack: assert property (
    @(posedge CLK_50M) disable iff (reset)
    sample_valid |-> $past(flash_rsp.ack)
  ) else report_event("sample_valid pulsed without a preceding ack");

  // Open bus cycle reads the word holding the expected sample
  a_bus_adr: assert property (
    @(posedge CLK_50M) disable iff (reset)
    flash_req.stb |-> (flash_req.adr == 23'($sampled(exp_index) >> 1))
  ) else report_value("wb_out.adr", $sampled(exp_index) >> 1, $sampled(flash_req.adr));

  a_bus_release: assert property (
    @(posedge CLK_50M) disable iff (reset)
    flash_rsp.ack |=> !(flash_req.cyc || flash_req.stb)
  ) else report_event("cyc or stb still high in the cycle after ack");

  a_display: assert property (
    @(posedge CLK_50M) disable iff (reset)
    (settle == 0) |-> (hex == exp_hex)
  ) else report_value("hex", $sampled(exp_hex), $sampled(hex));

  // ====================
  // Stimulus
  // ====================

  task automatic send_key(input logic [7:0] code);
    @(negedge CLK_50M);
    key_ascii  = code;
    key_strobe = 1'b1;
    @(negedge CLK_50M);
    key_strobe = 1'b0;
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic rst);
    @(negedge CLK_50M);
    speed_up    = up;
    speed_down  = down;
    speed_reset = rst;
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    repeat (2) @(negedge CLK_50M);
  endtask

  task automatic idle(input int cycles);
    for (int i = 0; i < cycles; i++)
      @(negedge CLK_50M);
  endtask

  // Counts pulses mid-cycle, timer restarts after each one
  task automatic wait_samples(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n)
    begin
      @(negedge CLK_50M);
      cycles = cycles + 1;
      if (sample_valid)
      begin
        seen   = seen + 1;
        cycles = 0;
      end
      else if (cycles >= sample_timeout)
      begin
        report_event($sformatf("timeout, no sample_valid within %0d cycles", sample_timeout));
        break;
      end
    end
  endtask

  task automatic finish_test(input string name);
    test_count = test_count + 1;
    $display("test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  initial
  begin
    reset             = 1'b1;
    key_ascii         = 8'h00;
    key_strobe        = 1'b0;
    speed_up          = 1'b0;
    speed_down        = 1'b0;
    speed_reset       = 1'b0;
    error_count       = 0;
    test_count        = 0;
    test_start_errors = 0;
    repeat (4) @(posedge CLK_50M);
    @(negedge CLK_50M);
    reset = 1'b0;

    idle(1000);
    finish_test("reset state");

    send_key("e");
    wait_samples(33);
    finish_test("forward play and wrap");

    send_key("d");
    idle(1000);
    send_key("x");
    idle(1000);
    send_key("E");
    wait_samples(2);
    send_key("x");
    wait_samples(2);
    finish_test("stop, resume and unknown key");

    send_key("b");
    wait_samples(8);
    send_key("f");
    wait_samples(4);
    finish_test("backward play and wrap");

    send_key("r");
    wait_samples(2);
    send_key("b");
    send_key("r");
    wait_samples(2);
    send_key("f");
    finish_test("restart");

    pulse_speed(1'b1, 1'b0, 1'b0);
    pulse_speed(1'b1, 1'b0, 1'b0);
    pulse_speed(1'b1, 1'b0, 1'b0);
    pulse_speed(1'b0, 1'b0, 1'b1);
    // Enough pulses to climb from 400 past the upper limit
    for (int i = 0; i < 600; i++)
      pulse_speed(1'b0, 1'b1, 1'b0);
    pulse_speed(1'b1, 1'b0, 1'b0);
    pulse_speed(1'b0, 1'b0, 1'b1);
    wait_samples(2);
    finish_test("speed control and display");

    $display("summary: %0d tests, %0d samples, %0d errors",
             test_count, sample_count, error_count);
    if (error_count == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: list.f
hw/ipod_pkg.sv
hw/key_command_decoder.sv
hw/speed_control.sv
hw/address_sequencer.sv
hw/flash_wb_reader.sv
hw/period_display.sv
hw/ipod_top.sv
bench/flash_wb_model.sv
bench/tb_ipod.sv
